// ==== include/rv_defs.svh ====
// Widths shared by the RV32I decode stage. Only RV_XLEN = 32 is supported,
// since the immediate layouts assume a 32-bit instruction word.
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN       32  // data and address width.
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS   32  // x0 included.

`endif

// ==== source/rv_isa_pkg.sv ====
// RV32I base encodings only. Compressed, M, A and system opcodes are not listed.
`default_nettype none
`include "rv_defs.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } store_f3_e;

    // shared by OP and OP_IMM.
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects sub and sra.

    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        opcode_e                   opcode;
    } inst_fields_t;

endpackage

`default_nettype wire

// ==== source/rv_ctrl_pkg.sv ====
// Control fields passed from decode to execute. The selector encodings are
// local to this pipeline and are not RISC-V encodings.
`default_nettype none
`include "rv_defs.svh"

package rv_ctrl_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_JALR,   // target add with bit 0 cleared in execute.
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_S,
        OP2_IMM_J,
        OP2_IMM_U,
        OP2_ZERO
    } op2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC} wb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        mem_op_e  mem_op;
        wb_sel_e  wb_sel;
        logic     rf_wen;
    } ctrl_t;

    // one in-flight instruction further down the pipe.
    typedef struct packed {
        logic                      valid;
        logic                      rf_wen;
        logic [`RV_REG_ADDR_W-1:0] wb_addr;
    } hazard_src_t;

    typedef struct packed {
        logic                      en;
        logic [`RV_REG_ADDR_W-1:0] addr;
        logic [`RV_XLEN-1:0]       data;
    } wb_write_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_XLEN-1:0]       inst;
        alu_op_e                   alu_op;
        mem_op_e                   mem_op;
        wb_sel_e                   wb_sel;
        logic                      rf_wen;
        logic [`RV_REG_ADDR_W-1:0] wb_addr;
        logic                      jmp_flg;
        logic [`RV_XLEN-1:0]       op1_data;
        logic [`RV_XLEN-1:0]       op2_data;
        logic [`RV_XLEN-1:0]       rs2_data;  // store data, never muxed.
        logic [`RV_XLEN-1:0]       imm_b;
    } exe_req_t;

endpackage

`default_nettype wire

// ==== source/inst_decoder.sv ====
// RV32I decode table. Any word outside it, reserved funct3 or funct7 values
// included, becomes a nop with no write and no memory access.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module inst_decoder (
    input  wire [`RV_XLEN-1:0] inst,
    output rv_ctrl_pkg::ctrl_t ctrl
);

function automatic rv_ctrl_pkg::ctrl_t mk(
    input rv_ctrl_pkg::alu_op_e  alu_op,
    input rv_ctrl_pkg::op1_sel_e op1_sel,
    input rv_ctrl_pkg::op2_sel_e op2_sel,
    input rv_ctrl_pkg::mem_op_e  mem_op,
    input rv_ctrl_pkg::wb_sel_e  wb_sel,
    input logic                  rf_wen
);
    mk = '{alu_op, op1_sel, op2_sel, mem_op, wb_sel, rf_wen};
endfunction

function automatic rv_ctrl_pkg::alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
        rv_isa_pkg::F3_ADD_SUB: arith_op = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
        rv_isa_pkg::F3_SLL:     arith_op = rv_ctrl_pkg::ALU_SLL;
        rv_isa_pkg::F3_SLT:     arith_op = rv_ctrl_pkg::ALU_SLT;
        rv_isa_pkg::F3_SLTU:    arith_op = rv_ctrl_pkg::ALU_SLTU;
        rv_isa_pkg::F3_XOR:     arith_op = rv_ctrl_pkg::ALU_XOR;
        rv_isa_pkg::F3_SRL_SRA: arith_op = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
        rv_isa_pkg::F3_OR:      arith_op = rv_ctrl_pkg::ALU_OR;
        default:                arith_op = rv_ctrl_pkg::ALU_AND;
    endcase
endfunction

rv_isa_pkg::inst_fields_t f;
rv_ctrl_pkg::mem_op_e     load_op;
rv_ctrl_pkg::mem_op_e     store_op;
rv_ctrl_pkg::alu_op_e     branch_op;
logic                     f7_alt;
logic                     op_legal;
logic                     imm_legal;
logic                     imm_alt;

assign f        = rv_isa_pkg::inst_fields_t'(inst);
assign f7_alt   = f.funct7 == rv_isa_pkg::F7_ALT;
// alternate funct7 is only defined for sub and sra.
assign op_legal = (f.funct7 == rv_isa_pkg::F7_BASE) ||
                  (f7_alt && (f.funct3 == rv_isa_pkg::F3_ADD_SUB ||
                              f.funct3 == rv_isa_pkg::F3_SRL_SRA));
// immediate shifts carry funct7 in imm[11:5], other immediates ignore it.
assign imm_legal = op_legal || !(f.funct3 == rv_isa_pkg::F3_SLL ||
                                 f.funct3 == rv_isa_pkg::F3_SRL_SRA);
assign imm_alt   = f7_alt && f.funct3 == rv_isa_pkg::F3_SRL_SRA;  // addi keeps bit 30.

always_comb begin
    case (f.funct3)
        rv_isa_pkg::F3_LB:  load_op = rv_ctrl_pkg::MEM_LB;
        rv_isa_pkg::F3_LH:  load_op = rv_ctrl_pkg::MEM_LH;
        rv_isa_pkg::F3_LW:  load_op = rv_ctrl_pkg::MEM_LW;
        rv_isa_pkg::F3_LBU: load_op = rv_ctrl_pkg::MEM_LBU;
        rv_isa_pkg::F3_LHU: load_op = rv_ctrl_pkg::MEM_LHU;
        default:            load_op = rv_ctrl_pkg::MEM_NONE;
    endcase
    case (f.funct3)
        rv_isa_pkg::F3_SB: store_op = rv_ctrl_pkg::MEM_SB;
        rv_isa_pkg::F3_SH: store_op = rv_ctrl_pkg::MEM_SH;
        rv_isa_pkg::F3_SW: store_op = rv_ctrl_pkg::MEM_SW;
        default:           store_op = rv_ctrl_pkg::MEM_NONE;
    endcase
    case (f.funct3)
        rv_isa_pkg::F3_BEQ:  branch_op = rv_ctrl_pkg::BR_BEQ;
        rv_isa_pkg::F3_BNE:  branch_op = rv_ctrl_pkg::BR_BNE;
        rv_isa_pkg::F3_BLT:  branch_op = rv_ctrl_pkg::BR_BLT;
        rv_isa_pkg::F3_BGE:  branch_op = rv_ctrl_pkg::BR_BGE;
        rv_isa_pkg::F3_BLTU: branch_op = rv_ctrl_pkg::BR_BLTU;
        rv_isa_pkg::F3_BGEU: branch_op = rv_ctrl_pkg::BR_BGEU;
        default:             branch_op = rv_ctrl_pkg::ALU_NONE;  // funct3 2 and 3 reserved.
    endcase
end

always_comb begin
    ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_ZERO, rv_ctrl_pkg::OP2_ZERO,
              rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE, 1'b0);  // nop.
    case (f.opcode)
        rv_isa_pkg::OPC_LOAD:
            if (load_op != rv_ctrl_pkg::MEM_NONE)
                ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_RS1, rv_ctrl_pkg::OP2_IMM_I,
                          load_op, rv_ctrl_pkg::WB_MEM, 1'b1);
        rv_isa_pkg::OPC_STORE:
            if (store_op != rv_ctrl_pkg::MEM_NONE)
                ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_RS1, rv_ctrl_pkg::OP2_IMM_S,
                          store_op, rv_ctrl_pkg::WB_NONE, 1'b0);
        rv_isa_pkg::OPC_OP:
            if (op_legal)
                ctrl = mk(arith_op(f.funct3, f7_alt), rv_ctrl_pkg::OP1_RS1,
                          rv_ctrl_pkg::OP2_RS2, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU, 1'b1);
        rv_isa_pkg::OPC_OP_IMM:
            if (imm_legal)
                ctrl = mk(arith_op(f.funct3, imm_alt), rv_ctrl_pkg::OP1_RS1,
                          rv_ctrl_pkg::OP2_IMM_I, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU, 1'b1);
        rv_isa_pkg::OPC_BRANCH:
            if (branch_op != rv_ctrl_pkg::ALU_NONE)
                ctrl = mk(branch_op, rv_ctrl_pkg::OP1_RS1, rv_ctrl_pkg::OP2_RS2,
                          rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE, 1'b0);
        rv_isa_pkg::OPC_JAL:
            ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_PC, rv_ctrl_pkg::OP2_IMM_J,
                      rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_PC, 1'b1);
        rv_isa_pkg::OPC_JALR:
            if (f.funct3 == rv_isa_pkg::F3_JALR)
                ctrl = mk(rv_ctrl_pkg::ALU_JALR, rv_ctrl_pkg::OP1_RS1, rv_ctrl_pkg::OP2_IMM_I,
                          rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_PC, 1'b1);
        rv_isa_pkg::OPC_LUI:
            ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_ZERO, rv_ctrl_pkg::OP2_IMM_U,
                      rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU, 1'b1);
        rv_isa_pkg::OPC_AUIPC:
            ctrl = mk(rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::OP1_PC, rv_ctrl_pkg::OP2_IMM_U,
                      rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU, 1'b1);
        default: ;
    endcase
end

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
// Immediate extraction and operand muxing. Register data must already have x0
// forced to zero by the register file.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module operand_select (
    input  wire [`RV_XLEN-1:0]      inst,
    input  wire rv_ctrl_pkg::ctrl_t ctrl,
    input  wire [`RV_XLEN-1:0]      pc,
    input  wire [`RV_XLEN-1:0]      rs1_data,
    input  wire [`RV_XLEN-1:0]      rs2_data,
    output logic [`RV_XLEN-1:0]     op1_data,
    output logic [`RV_XLEN-1:0]     op2_data,
    output logic [`RV_XLEN-1:0]     imm_b
);

logic [`RV_XLEN-1:0] imm_i;
logic [`RV_XLEN-1:0] imm_s;
logic [`RV_XLEN-1:0] imm_j;
logic [`RV_XLEN-1:0] imm_u;

assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
// b and j offsets count half-words, so bit 0 is always zero.
assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
assign imm_u = {inst[31:12], 12'b0};

always_comb begin
    case (ctrl.op1_sel)
        rv_ctrl_pkg::OP1_RS1: op1_data = rs1_data;
        rv_ctrl_pkg::OP1_PC:  op1_data = pc;
        default:              op1_data = '0;
    endcase
end

always_comb begin
    case (ctrl.op2_sel)
        rv_ctrl_pkg::OP2_RS2:   op2_data = rs2_data;
        rv_ctrl_pkg::OP2_IMM_I: op2_data = imm_i;
        rv_ctrl_pkg::OP2_IMM_S: op2_data = imm_s;
        rv_ctrl_pkg::OP2_IMM_J: op2_data = imm_j;
        rv_ctrl_pkg::OP2_IMM_U: op2_data = imm_u;
        default:                op2_data = '0;  // nop operand.
    endcase
end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
// Data hazard detection with no forwarding. Source fields are compared even
// for formats that do not read them, which can stall without need.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module hazard_unit (
    input  wire [`RV_XLEN-1:0]                  inst,
    input  wire rv_ctrl_pkg::hazard_src_t [2:0] hazard_srcs,  // exe, mem, wb.
    output logic                                stall
);

rv_isa_pkg::inst_fields_t f;
logic [2:0]               hit;

assign f = rv_isa_pkg::inst_fields_t'(inst);

always_comb begin
    for (int i = 0; i < 3; i++) begin
        hit[i] = hazard_srcs[i].valid && hazard_srcs[i].rf_wen &&
                 ((f.rs1 != '0 && hazard_srcs[i].wb_addr == f.rs1) ||
                  (f.rs2 != '0 && hazard_srcs[i].wb_addr == f.rs2));
    end
end

assign stall = |hit;

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// Register file without write-to-read bypass. A write is visible to reads
// from the cycle after its clock edge.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module reg_file (
    input  wire                            clk,
    input  wire                            rst,
    input  wire rv_ctrl_pkg::wb_write_t    wb_write,
    input  wire [`RV_REG_ADDR_W-1:0]       rs1_addr,
    input  wire [`RV_REG_ADDR_W-1:0]       rs2_addr,
    output logic [`RV_XLEN-1:0]            rs1_data,
    output logic [`RV_XLEN-1:0]            rs2_data
);

// x0 has no storage.
logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 1; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_write.en && wb_write.addr != '0) begin
        regs[wb_write.addr] <= wb_write.data;
    end
end

assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
// Decode stage with one cycle of latency. stall is combinational on inst and
// hazard_srcs, and upstream must hold pc and inst while it is high.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module decode_stage (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 in_valid,
    input  wire [`RV_XLEN-1:0]                  pc,
    input  wire [`RV_XLEN-1:0]                  inst,
    output logic                                stall,
    input  wire rv_ctrl_pkg::hazard_src_t [2:0] hazard_srcs,
    input  wire rv_ctrl_pkg::wb_write_t         wb_write,
    output logic                                out_valid,
    output rv_ctrl_pkg::exe_req_t               out_req
);

rv_isa_pkg::inst_fields_t f;
rv_ctrl_pkg::ctrl_t       ctrl;
rv_ctrl_pkg::exe_req_t    req_d;
logic [`RV_XLEN-1:0]      rs1_data;
logic [`RV_XLEN-1:0]      rs2_data;
logic [`RV_XLEN-1:0]      op1_data;
logic [`RV_XLEN-1:0]      op2_data;
logic [`RV_XLEN-1:0]      imm_b;
logic                     accept;

assign f = rv_isa_pkg::inst_fields_t'(inst);

inst_decoder u_dec (
    .inst (inst),
    .ctrl (ctrl)
);

reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .wb_write (wb_write),
    .rs1_addr (f.rs1),
    .rs2_addr (f.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

operand_select u_ops (
    .inst     (inst),
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .op1_data (op1_data),
    .op2_data (op2_data),
    .imm_b    (imm_b)
);

hazard_unit u_haz (
    .inst        (inst),
    .hazard_srcs (hazard_srcs),
    .stall       (stall)
);

always_comb begin
    req_d.pc       = pc;
    req_d.inst     = inst;
    req_d.alu_op   = ctrl.alu_op;
    req_d.mem_op   = ctrl.mem_op;
    req_d.wb_sel   = ctrl.wb_sel;
    req_d.rf_wen   = ctrl.rf_wen;
    req_d.wb_addr  = f.rd;
    req_d.jmp_flg  = ctrl.wb_sel == rv_ctrl_pkg::WB_PC;  // only jal and jalr link.
    req_d.op1_data = op1_data;
    req_d.op2_data = op2_data;
    req_d.rs2_data = rs2_data;
    req_d.imm_b    = imm_b;
end

assign accept = in_valid && !stall;

always_ff @(posedge clk) begin
    if (rst) begin
        out_valid <= 1'b0;
        out_req   <= '0;
    end else begin
        out_valid <= accept;
        if (accept) begin
            out_req <= req_d;  // held across bubbles.
        end
    end
end

endmodule

`default_nettype wire

// ==== tests/decode_stage_chk.sv ====
// Valid and stall timing checks bound into every decode_stage instance.
`timescale 1ns/10ps
`default_nettype none

module decode_stage_chk (
    input wire clk,
    input wire rst,
    input wire in_valid,
    input wire stall,
    input wire out_valid
);

int unsigned fail_count = 0;

reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high in the cycle after reset");
    end

// a stalled instruction is never handed on.
stall_blocks_valid: assert property (
    @(posedge clk) disable iff (rst) stall |=> !out_valid
) else begin
    fail_count++;
    $error("out_valid high in the cycle after stall");
end

valid_needs_accept: assert property (
    @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid && !stall)
) else begin
    fail_count++;
    $error("out_valid high without an accepted instruction one cycle before");
end

endmodule

bind decode_stage decode_stage_chk chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .stall     (stall),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== tests/decode_stage_tb.sv ====
// Directed decode stage test. Register contents come from an LCG preload, and
// each table entry is accepted or stalled in a single cycle, back to back.
`timescale 1ns/10ps
`default_nettype none
`include "rv_defs.svh"

module decode_stage_tb;

typedef rv_ctrl_pkg::hazard_src_t [2:0] haz_vec_t;

typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [`RV_XLEN-1:0]  inst;
    haz_vec_t             haz;
    logic                 stall;
    rv_ctrl_pkg::alu_op_e alu_op;
    rv_ctrl_pkg::mem_op_e mem_op;
    rv_ctrl_pkg::wb_sel_e wb_sel;
    logic                 rf_wen;
    logic                 jmp_flg;
    logic [`RV_XLEN-1:0]  op1;
    logic [`RV_XLEN-1:0]  op2;
    logic                 has_imm_b;  // imm_b only matters for branches.
    logic [`RV_XLEN-1:0]  imm_b;
} tcase_t;

localparam haz_vec_t NO_HAZ = '0;

logic                   clk;
logic                   rst;
logic                   in_valid;
logic [`RV_XLEN-1:0]    pc;
logic [`RV_XLEN-1:0]    inst;
logic                   stall;
haz_vec_t               hazard_srcs;
rv_ctrl_pkg::wb_write_t wb_write;
logic                   out_valid;
rv_ctrl_pkg::exe_req_t  out_req;

logic [`RV_XLEN-1:0] rf [0:`RV_NUM_REGS-1];  // model of the register file.
logic [31:0]         lcg_state;
logic [`RV_XLEN-1:0] held_pc;  // pc of the last accepted entry.
tcase_t              cases[$];
string               names[$];

always #5 clk = ~clk;

decode_stage dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .pc          (pc),
    .inst        (inst),
    .stall       (stall),
    .hazard_srcs (hazard_srcs),
    .wb_write    (wb_write),
    .out_valid   (out_valid),
    .out_req     (out_req)
);

always @(dut.chk.fail_count) begin
    if (dut.chk.fail_count != 0) begin
        $display("a valid or stall timing assertion failed in the bound checker");
        $display("=== FAIL ===");
        $fatal(1);
    end
end

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rs1, rs2);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rs1, rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// one in-flight source at stage idx while the other two stay idle.
function automatic haz_vec_t one_src(input int idx, input logic valid, input logic wen,
                                     input logic [4:0] addr);
    haz_vec_t v;
    v = '0;
    v[idx] = '{valid: valid, rf_wen: wen, wb_addr: addr};
    return v;
endfunction

task automatic report_mismatch(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] got);
    $display("FAIL %s %s: expected %h, actual %h", name, field, exp, got);
    $display("=== FAIL ===");
    $fatal(1);
endtask

task automatic check_field(input string name, input string field,
                           input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else report_mismatch(name, field, exp, got);
endtask

task automatic add_case(input string name, input tcase_t c);
    names.push_back(name);
    cases.push_back(c);
endtask

// register-register ALU entry with operands taken from the model.
task automatic add_rr(input string name, input logic [31:0] word,
                      input rv_ctrl_pkg::alu_op_e alu, input haz_vec_t haz, input logic stl);
    add_case(name, '{32'h200 + 4 * cases.size(), word, haz, stl, alu,
             rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU, 1'b1, 1'b0,
             rf[word[19:15]], rf[word[24:20]], 1'b0, 32'h0});
endtask

task automatic build_table();
    add_rr("add", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD, NO_HAZ, 1'b0);
    add_rr("sub", r_type(7'h20, 3'd0, 5'd4, 5'd5, 5'd6), rv_ctrl_pkg::ALU_SUB, NO_HAZ, 1'b0);
    add_rr("and", r_type(7'h00, 3'd7, 5'd7, 5'd8, 5'd9), rv_ctrl_pkg::ALU_AND, NO_HAZ, 1'b0);
    add_rr("or", r_type(7'h00, 3'd6, 5'd10, 5'd11, 5'd12), rv_ctrl_pkg::ALU_OR, NO_HAZ, 1'b0);
    add_rr("xor", r_type(7'h00, 3'd4, 5'd13, 5'd14, 5'd15), rv_ctrl_pkg::ALU_XOR, NO_HAZ, 1'b0);
    add_rr("sll", r_type(7'h00, 3'd1, 5'd16, 5'd17, 5'd18), rv_ctrl_pkg::ALU_SLL, NO_HAZ, 1'b0);
    add_rr("srl", r_type(7'h00, 3'd5, 5'd19, 5'd20, 5'd21), rv_ctrl_pkg::ALU_SRL, NO_HAZ, 1'b0);
    add_rr("sra", r_type(7'h20, 3'd5, 5'd22, 5'd23, 5'd24), rv_ctrl_pkg::ALU_SRA, NO_HAZ, 1'b0);
    add_rr("slt", r_type(7'h00, 3'd2, 5'd25, 5'd26, 5'd27), rv_ctrl_pkg::ALU_SLT, NO_HAZ, 1'b0);
    add_rr("sltu", r_type(7'h00, 3'd3, 5'd28, 5'd29, 5'd31), rv_ctrl_pkg::ALU_SLTU, NO_HAZ, 1'b0);
    add_case("lw_neg", '{32'h300, i_type(12'hffc, 3'd2, 5'd10, 5'd11, rv_isa_pkg::OPC_LOAD),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_LW, rv_ctrl_pkg::WB_MEM,
             1'b1, 1'b0, rf[11], 32'hffff_fffc, 1'b0, 32'h0});
    add_case("lbu_pos", '{32'h304, i_type(12'h7ff, 3'd4, 5'd12, 5'd13, rv_isa_pkg::OPC_LOAD),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_LBU, rv_ctrl_pkg::WB_MEM,
             1'b1, 1'b0, rf[13], 32'h0000_07ff, 1'b0, 32'h0});
    add_case("lh_min", '{32'h308, i_type(12'h800, 3'd1, 5'd14, 5'd15, rv_isa_pkg::OPC_LOAD),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_LH, rv_ctrl_pkg::WB_MEM,
             1'b1, 1'b0, rf[15], 32'hffff_f800, 1'b0, 32'h0});
    add_case("sw_neg", '{32'h30c, s_type(12'hff8, 3'd2, 5'd15, 5'd14), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_SW, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, rf[15], 32'hffff_fff8, 1'b0, 32'h0});
    add_case("sb_pos", '{32'h310, s_type(12'h123, 3'd0, 5'd17, 5'd16), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_SB, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, rf[17], 32'h0000_0123, 1'b0, 32'h0});
    add_case("beq_neg", '{32'h400, b_type(13'h1ff0, 3'd0, 5'd18, 5'd19), NO_HAZ, 1'b0,
             rv_ctrl_pkg::BR_BEQ, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, rf[18], rf[19], 1'b1, 32'hffff_fff0});
    add_case("bltu_pos", '{32'h404, b_type(13'h0ffe, 3'd6, 5'd20, 5'd21), NO_HAZ, 1'b0,
             rv_ctrl_pkg::BR_BLTU, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, rf[20], rf[21], 1'b1, 32'h0000_0ffe});
    add_case("bge_min", '{32'h408, b_type(13'h1000, 3'd5, 5'd22, 5'd23), NO_HAZ, 1'b0,
             rv_ctrl_pkg::BR_BGE, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, rf[22], rf[23], 1'b1, 32'hffff_f000});
    add_case("jal_pos", '{32'h500, j_type(21'h000800, 5'd1), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_PC,
             1'b1, 1'b1, 32'h500, 32'h0000_0800, 1'b0, 32'h0});
    add_case("jal_neg", '{32'h504, j_type(21'h1ffffc, 5'd5), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_PC,
             1'b1, 1'b1, 32'h504, 32'hffff_fffc, 1'b0, 32'h0});
    add_case("jalr", '{32'h508, i_type(12'h00c, 3'd0, 5'd1, 5'd5, rv_isa_pkg::OPC_JALR),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_JALR, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_PC,
             1'b1, 1'b1, rf[5], 32'h0000_000c, 1'b0, 32'h0});
    add_case("lui", '{32'h600, u_type(20'habcde, 5'd6, rv_isa_pkg::OPC_LUI), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU,
             1'b1, 1'b0, 32'h0, 32'habcd_e000, 1'b0, 32'h0});
    add_case("auipc", '{32'h604, u_type(20'h80000, 5'd7, rv_isa_pkg::OPC_AUIPC), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU,
             1'b1, 1'b0, 32'h604, 32'h8000_0000, 1'b0, 32'h0});
    add_case("addi_neg", '{32'h608, i_type(12'hfff, 3'd0, 5'd8, 5'd9, rv_isa_pkg::OPC_OP_IMM),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU,
             1'b1, 1'b0, rf[9], 32'hffff_ffff, 1'b0, 32'h0});
    add_case("srai", '{32'h60c, i_type(12'h403, 3'd5, 5'd10, 5'd11, rv_isa_pkg::OPC_OP_IMM),
             NO_HAZ, 1'b0, rv_ctrl_pkg::ALU_SRA, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_ALU,
             1'b1, 1'b0, rf[11], 32'h0000_0403, 1'b0, 32'h0});
    // hazard entries all use add x3, x1, x2 unless noted.
    add_rr("haz_exe_rs1", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(0, 1'b1, 1'b1, 5'd1), 1'b1);
    add_rr("haz_mem_rs2", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(1, 1'b1, 1'b1, 5'd2), 1'b1);
    add_rr("haz_wb_rs1", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(2, 1'b1, 1'b1, 5'd1), 1'b1);
    add_rr("haz_invalid", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(0, 1'b0, 1'b1, 5'd1), 1'b0);
    add_rr("haz_no_wen", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(1, 1'b1, 1'b0, 5'd2), 1'b0);
    add_rr("haz_rd_only", r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(2, 1'b1, 1'b1, 5'd3), 1'b0);
    add_rr("haz_x0", r_type(7'h00, 3'd0, 5'd3, 5'd0, 5'd2), rv_ctrl_pkg::ALU_ADD,
           one_src(0, 1'b1, 1'b1, 5'd0), 1'b0);
    add_rr("x0_read", r_type(7'h00, 3'd0, 5'd3, 5'd0, 5'd0), rv_ctrl_pkg::ALU_ADD,
           NO_HAZ, 1'b0);
    add_case("undef", '{32'h700, 32'hffff_ffff, NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, 32'h0, 32'h0, 1'b0, 32'h0});
    add_case("mul_nop", '{32'h704, r_type(7'h01, 3'd0, 5'd3, 5'd1, 5'd2), NO_HAZ, 1'b0,
             rv_ctrl_pkg::ALU_ADD, rv_ctrl_pkg::MEM_NONE, rv_ctrl_pkg::WB_NONE,
             1'b0, 1'b0, 32'h0, 32'h0, 1'b0, 32'h0});
endtask

task automatic check_outputs(input int k);
    tcase_t c;
    string  nm;
    c  = cases[k];
    nm = names[k];
    check_field(nm, "out_valid", 32'(!c.stall), 32'(out_valid));
    if (!c.stall) begin
        check_field(nm, "alu_op", 32'(c.alu_op), 32'(out_req.alu_op));
        check_field(nm, "mem_op", 32'(c.mem_op), 32'(out_req.mem_op));
        check_field(nm, "wb_sel", 32'(c.wb_sel), 32'(out_req.wb_sel));
        check_field(nm, "rf_wen", 32'(c.rf_wen), 32'(out_req.rf_wen));
        check_field(nm, "jmp_flg", 32'(c.jmp_flg), 32'(out_req.jmp_flg));
        check_field(nm, "op1_data", c.op1, out_req.op1_data);
        check_field(nm, "op2_data", c.op2, out_req.op2_data);
        check_field(nm, "pc", c.pc, out_req.pc);
        check_field(nm, "inst", c.inst, out_req.inst);
        check_field(nm, "wb_addr", 32'(c.inst[11:7]), 32'(out_req.wb_addr));
        check_field(nm, "rs2_data", rf[c.inst[24:20]], out_req.rs2_data);
        if (c.has_imm_b) begin
            check_field(nm, "imm_b", c.imm_b, out_req.imm_b);
        end
        held_pc = c.pc;
    end else begin
        // a stalled entry leaves the previous request in place.
        check_field(nm, "held pc", held_pc, out_req.pc);
    end
endtask

task automatic wait_reset_done();
    for (int n = 0; n < 8; n++) begin
        if (!out_valid) begin
            return;
        end
        @(posedge clk);
        #1;
    end
    $display("out_valid did not go low within 8 cycles after reset");
    $display("=== FAIL ===");
    $fatal(1);
endtask

initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    pc          = '0;
    inst        = '0;
    hazard_srcs = '0;
    wb_write    = '0;
    lcg_state   = 32'd6;
    rf[0]       = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_reset_done();
    check_field("reset", "out_req.pc", 32'h0, out_req.pc);
    check_field("reset", "out_req.inst", 32'h0, out_req.inst);
    check_field("reset", "out_req.op1_data", 32'h0, out_req.op1_data);

    for (int r = 1; r < `RV_NUM_REGS; r++) begin
        @(posedge clk);
        #1;
        rf[r]    = lcg_next();
        wb_write = '{en: 1'b1, addr: 5'(r), data: rf[r]};
    end
    @(posedge clk);
    #1;
    wb_write = '{en: 1'b1, addr: 5'd0, data: 32'hdead_beef};  // x0 must stay zero.
    @(posedge clk);
    #1;
    wb_write = '0;
    build_table();

    // outputs of entry i-1 are checked while entry i is driven.
    for (int i = 0; i <= cases.size(); i++) begin
        @(posedge clk);
        #1;
        if (i > 0) begin
            check_outputs(i - 1);
        end
        if (i < cases.size()) begin
            in_valid    = 1'b1;
            pc          = cases[i].pc;
            inst        = cases[i].inst;
            hazard_srcs = cases[i].haz;
            #1;
            check_field(names[i], "stall", 32'(cases[i].stall), 32'(stall));
        end else begin
            in_valid    = 1'b0;
            hazard_srcs = '0;
        end
    end
    $display("=== PASS ===");
    $finish;
end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/inst_decoder.sv
source/operand_select.sv
source/hazard_unit.sv
source/reg_file.sv
source/decode_stage.sv
tests/decode_stage_chk.sv
tests/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: rv_decode_stage

export_include_dirs:
  - include

sources:
  - source/rv_isa_pkg.sv
  - source/rv_ctrl_pkg.sv
  - source/inst_decoder.sv
  - source/operand_select.sv
  - source/hazard_unit.sv
  - source/reg_file.sv
  - source/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_chk.sv
      - tests/decode_stage_tb.sv
